// File: source/SocPkg.sv
// Shared line geometry, memory map and access types.
// Memory lines are 16 bytes. The core addresses bytes but every access is one line.
// The memory region starts at line MemLineBase. MemLineEnd is only the default size
// and the real size comes from the top parameter MemLines.
package SocPkg;

    localparam int LineBytes = 16;
    localparam int LineWidth = LineBytes * 8;

    // Byte address seen by the core, and the same address in line units
    typedef logic [31:0] addr_t;
    typedef logic [27:0] lineIndex_t;

    localparam lineIndex_t MemLineBase = 28'h000_0000;
    localparam lineIndex_t MemLineEnd = 28'h000_0040;

    // UART transmit register at byte address 0x4000_0000
    localparam lineIndex_t UartLine = 28'h400_0000;

    typedef enum logic [1:0] {
        TargetMem  = 2'h0,
        TargetUart = 2'h1,
        TargetNone = 2'h2
    } target_e;

    // Loader fills the byte view; memory and response move the whole word.
    // UART takes bytes[0]
    typedef union packed {
        logic [LineBytes-1:0][7:0] bytes;
        logic [LineWidth-1:0] word;
    } line_u;

    typedef enum logic [1:0] {
        BootLoad = 2'h0,
        BootRun  = 2'h1
    } bootState_e;

endpackage

// File: source/LineAccessIf.sv
// One line-wide access between the decoder and the line memory.
// The requester holds enable and the request fields until done.
// done is a single-cycle pulse and readValue is valid with it.
interface LineAccessIf;
    import SocPkg::*;

    logic enable;
    logic isWrite;
    lineIndex_t lineIndex;
    line_u writeValue;
    logic done;
    line_u readValue;

    modport requester (
        output enable, isWrite, lineIndex, writeValue,
        input done, readValue
    );

    modport target (
        input enable, isWrite, lineIndex, writeValue,
        output done, readValue
    );

    modport observer (
        input enable, done, readValue
    );

endinterface

// File: source/BootLoader.sv
// Program loader. Bytes arrive under credit flow control and are packed into lines.
// The source may hold at most LoadCredits unreturned bytes.
// loadSize must be stable from reset until the boot state reaches BootRun.
// Bytes sent beyond loadSize stay in the buffer and return no credit.
// A final partial line is written with its unused bytes zero.
module BootLoader #(
    parameter int LoadCredits = 4
) (
    input logic clk,
    input logic rst,
    input logic loadValid,
    input logic [7:0] loadByte,
    input logic [31:0] loadSize,
    output logic loadCredit,
    output logic coreReset,
    output SocPkg::bootState_e bootState,
    output logic loaderEnable,
    output SocPkg::lineIndex_t loaderLineIndex,
    output SocPkg::line_u loaderWriteValue,
    input logic loaderDone
);
    import SocPkg::*;

    localparam int PtrWidth = (LoadCredits > 1) ? $clog2(LoadCredits) : 1;

    logic [7:0] fifo [LoadCredits];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [PtrWidth:0] fill;
    logic pop;

    logic [31:0] byteCount;
    logic [31:0] lastByteAddr;
    logic writePending;
    line_u packLine;

    // Buffer exit is blocked while a line write is in flight
    assign pop = (fill != '0) && !writePending && (bootState == BootLoad)
        && (byteCount < loadSize);

    // Line of the most recently packed byte
    assign lastByteAddr = byteCount - 32'd1;
    assign loaderLineIndex = lastByteAddr[31:4];
    assign loaderEnable = writePending;
    assign loaderWriteValue = packLine;

    always_ff @(posedge clk) begin
        if (loadValid) begin
            fifo[wrPtr] <= loadByte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill <= '0;
            loadCredit <= 1'b0;
        end else begin
            if (loadValid) begin
                wrPtr <= (wrPtr == PtrWidth'(LoadCredits - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(LoadCredits - 1)) ? '0 : rdPtr + 1'b1;
            end
            fill <= fill + (PtrWidth + 1)'(loadValid) - (PtrWidth + 1)'(pop);
            loadCredit <= pop;
        end
    end

    // Packer, byte counter and line write request
    always_ff @(posedge clk) begin
        if (rst) begin
            byteCount <= '0;
            writePending <= 1'b0;
            packLine <= '0;
        end else if (pop) begin
            packLine.bytes[byteCount[3:0]] <= fifo[rdPtr];
            byteCount <= byteCount + 32'd1;
            writePending <= (byteCount[3:0] == 4'hF) || (byteCount + 32'd1 == loadSize);
        end else if (writePending && loaderDone) begin
            writePending <= 1'b0;
            packLine <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bootState <= BootLoad;
            coreReset <= 1'b1;
        end else begin
            if (bootState == BootLoad && byteCount >= loadSize && !writePending) begin
                bootState <= BootRun;
            end
            // Core leaves reset one cycle after the switch to run
            if (bootState == BootRun) begin
                coreReset <= 1'b0;
            end
        end
    end

endmodule

// File: source/AccessDecode.sv
// Address decoder and requester mux for the line memory.
// During load the loader owns the memory; the core is ignored until BootRun.
// The core line index is classified as UART, memory or unmapped.
// Only memory accesses raise the memory enable.
module AccessDecode #(
    parameter int MemLines = int'(SocPkg::MemLineEnd - SocPkg::MemLineBase)
) (
    input logic clk,
    input logic rst,
    input SocPkg::bootState_e bootState,
    input logic loaderEnable,
    input SocPkg::lineIndex_t loaderLineIndex,
    input SocPkg::line_u loaderWriteValue,
    input logic reqValid,
    input SocPkg::addr_t reqAddr,
    input logic reqIsWrite,
    input SocPkg::line_u reqWriteValue,
    input logic uartIdle,
    LineAccessIf.requester mem,
    output SocPkg::target_e target,
    output logic uartStart,
    output logic [7:0] uartByte
);
    import SocPkg::*;

    localparam lineIndex_t MemEnd = lineIndex_t'(MemLineBase + MemLines);

    lineIndex_t reqLine;
    logic startGuard;

    assign reqLine = reqAddr[31:4];

    always_comb begin
        if (bootState == BootLoad) begin
            target = TargetMem;
            mem.enable = loaderEnable;
            mem.isWrite = 1'b1;
            mem.lineIndex = loaderLineIndex;
            mem.writeValue = loaderWriteValue;
        end else begin
            if (reqLine == UartLine) begin
                target = TargetUart;
            end else if (reqLine >= MemLineBase && reqLine < MemEnd) begin
                target = TargetMem;
            end else begin
                target = TargetNone;
            end
            mem.enable = reqValid && (target == TargetMem);
            mem.isWrite = reqIsWrite;
            // Memory is indexed from the start of its region
            mem.lineIndex = reqLine - MemLineBase;
            mem.writeValue = reqWriteValue;
        end
    end

    // One start per request; the guard covers the cycle right after a start
    assign uartStart = (bootState == BootRun) && reqValid && reqIsWrite
        && (target == TargetUart) && uartIdle && !startGuard;
    assign uartByte = reqWriteValue.bytes[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            startGuard <= 1'b0;
        end else begin
            startGuard <= uartStart;
        end
    end

endmodule

// File: source/LineMemory.sv
// On-chip line memory with a registered read.
// done pulses one cycle after enable. An enable still held during done is
// not served again, so a held request costs exactly one access.
// A write returns the old line contents as read data.
// lineIndex must be below MemLines; upper index bits are not checked.
module LineMemory #(
    parameter int MemLines = int'(SocPkg::MemLineEnd - SocPkg::MemLineBase)
) (
    input logic clk,
    input logic rst,
    LineAccessIf.target acc
);
    import SocPkg::*;

    localparam int AddrWidth = (MemLines > 1) ? $clog2(MemLines) : 1;

    line_u lines [MemLines];
    logic [AddrWidth-1:0] index;
    logic accept;
    logic doneReg;
    line_u readReg;

    assign index = acc.lineIndex[AddrWidth-1:0];
    assign accept = acc.enable && !doneReg;

    always_ff @(posedge clk) begin
        if (accept) begin
            readReg <= lines[index];
            if (acc.isWrite) begin
                lines[index] <= acc.writeValue;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            doneReg <= 1'b0;
        end else begin
            doneReg <= accept;
        end
    end

    assign acc.done = doneReg;
    assign acc.readValue = readReg;

endmodule

// File: source/UartTransmitter.sv
// UART transmitter, 8N1, least significant bit first.
// Each bit lasts ClocksPerBit clocks. start is taken only while idle.
// idle drops in the cycle after start and rises after the full stop bit.
module UartTransmitter #(
    parameter int ClocksPerBit = 8
) (
    input logic clk,
    input logic rst,
    input logic start,
    input logic [7:0] txByte,
    output logic idle,
    output logic uartTx
);
    localparam int CountWidth = (ClocksPerBit > 1) ? $clog2(ClocksPerBit) : 1;

    logic busy;
    logic [CountWidth-1:0] baudCount;
    logic [3:0] bitIndex;
    // Stop, data, start; bit 0 is on the line
    logic [9:0] frame;

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            frame <= {1'b1, txByte, 1'b0};
        end else if (busy && baudCount == CountWidth'(ClocksPerBit - 1)) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            baudCount <= '0;
            bitIndex <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                baudCount <= '0;
                bitIndex <= '0;
            end
        end else if (baudCount == CountWidth'(ClocksPerBit - 1)) begin
            baudCount <= '0;
            // Ten bits per frame
            if (bitIndex == 4'd9) begin
                busy <= 1'b0;
            end else begin
                bitIndex <= bitIndex + 4'd1;
            end
        end else begin
            baudCount <= baudCount + 1'b1;
        end
    end

    assign idle = !busy;
    assign uartTx = busy ? frame[0] : 1'b1;

endmodule

// File: source/AccessResult.sv
// Response stage for the core request port.
// Memory accesses complete with the memory's done, UART writes complete when
// the transmitter is idle, everything else completes at once with zero.
// No response is given while loading.
module AccessResult (
    LineAccessIf.observer mem,
    input SocPkg::target_e target,
    input SocPkg::bootState_e bootState,
    input logic reqValid,
    input logic reqIsWrite,
    input logic uartIdle,
    output logic respDone,
    output SocPkg::line_u respReadValue
);
    import SocPkg::*;

    always_comb begin
        respDone = 1'b0;
        respReadValue = '0;
        if (bootState == BootRun && reqValid) begin
            case (target)
                TargetMem: begin
                    respDone = mem.done;
                    respReadValue = mem.readValue;
                end
                // UART reads always return zero right away
                TargetUart: begin
                    respDone = !reqIsWrite || uartIdle;
                end
                default: begin
                    respDone = 1'b1;
                end
            endcase
        end
    end

endmodule

// File: source/SocTop.sv
// Boot-and-run system top level.
// A program is loaded from the byte stream into line memory, then the core
// request port is served. loadSize must be stable from reset until coreReset
// falls. The core keeps one request outstanding and holds it until respDone.
// UART transmit lives at byte address 0x4000_0000; only byte 0 is sent.
module SocTop #(
    parameter int MemLines = 64,
    parameter int LoadCredits = 4,
    parameter int ClocksPerBit = 8
) (
    input logic clk,
    input logic rst,
    input logic loadValid,
    input logic [7:0] loadByte,
    input logic [31:0] loadSize,
    output logic loadCredit,
    input logic reqValid,
    input SocPkg::addr_t reqAddr,
    input logic reqIsWrite,
    input logic [SocPkg::LineWidth-1:0] reqWriteValue,
    output logic respDone,
    output logic [SocPkg::LineWidth-1:0] respReadValue,
    output logic coreReset,
    output logic uartTx
);
    import SocPkg::*;

    bootState_e bootState;
    logic loaderEnable;
    lineIndex_t loaderLineIndex;
    line_u loaderWriteValue;
    target_e target;
    logic uartStart;
    logic [7:0] uartByte;
    logic uartIdle;
    line_u reqLine;
    line_u respLine;

    assign reqLine = reqWriteValue;
    assign respReadValue = respLine.word;

    LineAccessIf memIf ();

    BootLoader #(
        .LoadCredits(LoadCredits)
    ) bootLoader_i (
        .clk(clk),
        .rst(rst),
        .loadValid(loadValid),
        .loadByte(loadByte),
        .loadSize(loadSize),
        .loadCredit(loadCredit),
        .coreReset(coreReset),
        .bootState(bootState),
        .loaderEnable(loaderEnable),
        .loaderLineIndex(loaderLineIndex),
        .loaderWriteValue(loaderWriteValue),
        .loaderDone(memIf.done)
    );

    AccessDecode #(
        .MemLines(MemLines)
    ) accessDecode_i (
        .clk(clk),
        .rst(rst),
        .bootState(bootState),
        .loaderEnable(loaderEnable),
        .loaderLineIndex(loaderLineIndex),
        .loaderWriteValue(loaderWriteValue),
        .reqValid(reqValid),
        .reqAddr(reqAddr),
        .reqIsWrite(reqIsWrite),
        .reqWriteValue(reqLine),
        .uartIdle(uartIdle),
        .mem(memIf.requester),
        .target(target),
        .uartStart(uartStart),
        .uartByte(uartByte)
    );

    LineMemory #(
        .MemLines(MemLines)
    ) lineMemory_i (
        .clk(clk),
        .rst(rst),
        .acc(memIf.target)
    );

    UartTransmitter #(
        .ClocksPerBit(ClocksPerBit)
    ) uartTransmitter_i (
        .clk(clk),
        .rst(rst),
        .start(uartStart),
        .txByte(uartByte),
        .idle(uartIdle),
        .uartTx(uartTx)
    );

    AccessResult accessResult_i (
        .mem(memIf.observer),
        .target(target),
        .bootState(bootState),
        .reqValid(reqValid),
        .reqIsWrite(reqIsWrite),
        .uartIdle(uartIdle),
        .respDone(respDone),
        .respReadValue(respLine)
    );

endmodule

// File: sim/SocTop_checker.sv
// Concurrent assertions on the top-level ports, bound into the top level.
// failCount counts failing assertions so the testbench can see them at the end.
// Byte and credit counters wrap after 2**31 transfers.
module SocTop_checker (
    input logic clk,
    input logic rst,
    input logic loadValid,
    input logic loadCredit,
    input logic reqValid,
    input logic respDone,
    input logic coreReset,
    input logic uartTx
);
    int acceptCount;
    int creditCount;
    int failCount = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            acceptCount <= 0;
            creditCount <= 0;
        end else begin
            if (loadValid) begin
                acceptCount <= acceptCount + 1;
            end
            if (loadCredit) begin
                creditCount <= creditCount + 1;
            end
        end
    end

    // A credit only returns for a byte already taken
    creditBound: assert property (@(posedge clk) disable iff (rst)
        loadCredit |-> creditCount < acceptCount)
    else begin
        failCount++;
        $error("loadCredit pulse without a matching accepted byte");
    end

    doneWithRequest: assert property (@(posedge clk) disable iff (rst)
        respDone |-> reqValid)
    else begin
        failCount++;
        $error("respDone high without reqValid");
    end

    idleDuringBoot: assert property (@(posedge clk) disable iff (rst)
        coreReset |-> uartTx)
    else begin
        failCount++;
        $error("uartTx left idle while coreReset is high");
    end

endmodule

bind SocTop SocTop_checker socTopChecker_i (
    .clk(clk),
    .rst(rst),
    .loadValid(loadValid),
    .loadCredit(loadCredit),
    .reqValid(reqValid),
    .respDone(respDone),
    .coreReset(coreReset),
    .uartTx(uartTx)
);

// File: sim/SocTop_tb.sv
// Directed testbench for the boot-and-run top level.
// Plays the program source under credit flow control and the core request port.
// Inputs change on the falling clock edge. Outputs are sampled at or just after
// the falling edge, where they are stable.
// The UART frame decoder assumes an even ClocksPerBit of at least 4.
module SocTop_tb;
    import SocPkg::*;

    localparam int MemLines = 64;
    localparam int LoadCredits = 4;
    localparam int ClocksPerBit = 8;
    localparam int ProgramBytes = 70;
    localparam int ResetCycles = 3;
    localparam int ResetCheckCycles = 4;
    localparam int FrameCycles = 10 * ClocksPerBit;
    localparam int AccessCycles = 3;
    localparam int AccessCount = 20;
    // Packing, line writes and the boot switch stay well under four cycles per byte
    localparam int LoadBudget = ProgramBytes * 4 + 40;
    localparam int WatchdogCycles = ResetCycles + ResetCheckCycles + LoadBudget
        + AccessCount * AccessCycles + 3 * FrameCycles + 100;
    localparam addr_t UartAddr = 32'h4000_0000;
    // First line past memory, its low index bits alias line 0
    localparam addr_t UnmappedAddr = addr_t'(MemLines * LineBytes);

    logic clk;
    logic rst;
    logic loadValid;
    logic [7:0] loadByte;
    logic [31:0] loadSize;
    logic loadCredit;
    logic reqValid;
    addr_t reqAddr;
    logic reqIsWrite;
    logic [LineWidth-1:0] reqWriteValue;
    logic respDone;
    logic [LineWidth-1:0] respReadValue;
    logic coreReset;
    logic uartTx;

    logic [7:0] progBytes [ProgramBytes];
    int framesSeen;

    SocTop #(
        .MemLines(MemLines),
        .LoadCredits(LoadCredits),
        .ClocksPerBit(ClocksPerBit)
    ) SocTop_i (
        .clk(clk),
        .rst(rst),
        .loadValid(loadValid),
        .loadByte(loadByte),
        .loadSize(loadSize),
        .loadCredit(loadCredit),
        .reqValid(reqValid),
        .reqAddr(reqAddr),
        .reqIsWrite(reqIsWrite),
        .reqWriteValue(reqWriteValue),
        .respDone(respDone),
        .respReadValue(respReadValue),
        .coreReset(coreReset),
        .uartTx(uartTx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a test did not finish", WatchdogCycles);
        $display("TESTBENCH FAILED");
        $fatal(1, "Timeout");
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic compareLine(input string name, input line_u actual, input line_u expected);
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch %s: actual 0x%h expected 0x%h",
                name, actual.word, expected.word));
        end
    endtask

    task automatic compareBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch %s: actual 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic compareByte(input string name, input logic [7:0] actual,
            input logic [7:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("Mismatch %s: actual 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    function automatic line_u randomLine();
        line_u line;
        for (int w = 0; w < LineWidth / 32; w++) begin
            line.word[w*32 +: 32] = $urandom();
        end
        return line;
    endfunction

    // Line as loaded: bytes in stream order, zero past the end of the program
    function automatic line_u expectedLine(input int index);
        line_u line;
        line = '0;
        for (int j = 0; j < LineBytes; j++) begin
            if (index * LineBytes + j < ProgramBytes) begin
                line.bytes[j] = progBytes[index * LineBytes + j];
            end
        end
        return line;
    endfunction

    // One core request held until respDone, called at a falling edge
    task automatic coreAccess(input addr_t addr, input logic isWrite, input line_u value,
            output line_u readValue, output int waited);
        waited = 0;
        reqValid = 1'b1;
        reqAddr = addr;
        reqIsWrite = isWrite;
        reqWriteValue = value.word;
        #1;
        while (!respDone) begin
            if (waited == 2 * FrameCycles) begin
                abortRun($sformatf("respDone never arrived for address 0x%h", addr));
            end
            @(negedge clk);
            #1;
            waited++;
        end
        readValue.word = respReadValue;
        @(negedge clk);
        reqValid = 1'b0;
    endtask

    task automatic memAccess(input int index, input logic isWrite, input line_u value,
            output line_u readValue);
        int waited;
        coreAccess(addr_t'(index * LineBytes), isWrite, value, readValue, waited);
        if (waited != 1) begin
            abortRun($sformatf("Memory respDone came %0d cycles after reqValid, not 1", waited));
        end
    endtask

    // Samples each bit near its middle, counting from the falling edge after the start
    task automatic receiveFrame(output logic [7:0] data);
        int cycles;
        cycles = 0;
        data = '0;
        @(negedge clk);
        while (uartTx) begin
            if (cycles == 3 * FrameCycles) begin
                abortRun("No UART start bit seen on uartTx");
            end
            @(negedge clk);
            cycles++;
        end
        repeat (ClocksPerBit / 2 - 1) @(negedge clk);
        compareBit("uartTx start bit", uartTx, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (ClocksPerBit) @(negedge clk);
            data[i] = uartTx;
        end
        repeat (ClocksPerBit) @(negedge clk);
        compareBit("uartTx stop bit", uartTx, 1'b1);
        framesSeen++;
    endtask

    task automatic checkResetState();
        repeat (ResetCheckCycles) begin
            compareBit("coreReset", coreReset, 1'b1);
            compareBit("uartTx", uartTx, 1'b1);
            compareBit("respDone", respDone, 1'b0);
            compareBit("loadCredit", loadCredit, 1'b0);
            @(negedge clk);
        end
    endtask

    // Source model: sends only while it holds a credit
    task automatic loadProgram();
        int credits;
        int sent;
        int returned;
        int cycles;
        credits = LoadCredits;
        sent = 0;
        returned = 0;
        cycles = 0;
        while (sent < ProgramBytes || returned < ProgramBytes || coreReset) begin
            if (cycles == LoadBudget) begin
                abortRun($sformatf("Load stalled: %0d sent, %0d credits back, coreReset %0b",
                    sent, returned, coreReset));
            end
            if (loadCredit) begin
                credits++;
                returned++;
            end
            if (returned > sent) begin
                abortRun("More credits came back than bytes were sent");
            end
            if (credits > 0 && sent < ProgramBytes) begin
                loadValid = 1'b1;
                loadByte = progBytes[sent];
                credits--;
                sent++;
            end else begin
                loadValid = 1'b0;
            end
            if (sent - returned > LoadCredits) begin
                abortRun("Source holds more unreturned bytes than credits");
            end
            if (sent < ProgramBytes) begin
                compareBit("coreReset", coreReset, 1'b1);
            end
            @(negedge clk);
            cycles++;
        end
        loadValid = 1'b0;
    endtask

    task automatic readBackProgram();
        line_u readValue;
        for (int i = 0; i < (ProgramBytes + LineBytes - 1) / LineBytes; i++) begin
            memAccess(i, 1'b0, '0, readValue);
            compareLine($sformatf("respReadValue line %0d", i), readValue, expectedLine(i));
        end
    endtask

    task automatic writeThenRead();
        int indices [4];
        line_u values [4];
        line_u readValue;
        indices = '{5, 17, 40, MemLines - 1};
        for (int i = 0; i < 4; i++) begin
            values[i] = randomLine();
            memAccess(indices[i], 1'b1, values[i], readValue);
        end
        for (int i = 0; i < 4; i++) begin
            memAccess(indices[i], 1'b0, '0, readValue);
            compareLine($sformatf("respReadValue line %0d", indices[i]), readValue, values[i]);
        end
    endtask

    task automatic uartWrites();
        line_u first;
        line_u second;
        line_u readValue;
        int waited;
        logic [7:0] rxFirst;
        logic [7:0] rxSecond;
        first = randomLine();
        second = randomLine();
        fork
            begin
                receiveFrame(rxFirst);
                receiveFrame(rxSecond);
            end
            begin
                coreAccess(UartAddr, 1'b1, first, readValue, waited);
                if (waited != 0) begin
                    abortRun("UART write to an idle transmitter was not done at once");
                end
                coreAccess(UartAddr, 1'b1, second, readValue, waited);
                if (framesSeen < 1) begin
                    abortRun("Second UART write was done before the first frame ended");
                end
            end
        join
        compareByte("uartTx first frame", rxFirst, first.bytes[0]);
        compareByte("uartTx second frame", rxSecond, second.bytes[0]);
        coreAccess(UartAddr, 1'b0, '0, readValue, waited);
        if (waited != 0) begin
            abortRun("UART read was not done at once");
        end
        compareLine("respReadValue UART read", readValue, '0);
    endtask

    task automatic unmappedAccess();
        line_u readValue;
        int waited;
        coreAccess(UnmappedAddr, 1'b0, '0, readValue, waited);
        if (waited != 0) begin
            abortRun("Unmapped read was not done at once");
        end
        compareLine("respReadValue unmapped read", readValue, '0);
        coreAccess(UnmappedAddr, 1'b1, randomLine(), readValue, waited);
        if (waited != 0) begin
            abortRun("Unmapped write was not done at once");
        end
        memAccess(0, 1'b0, '0, readValue);
        compareLine("respReadValue line 0", readValue, expectedLine(0));
    endtask

    initial begin
        void'($urandom(32'h672));
        rst = 1'b1;
        loadValid = 1'b0;
        loadByte = '0;
        loadSize = ProgramBytes;
        reqValid = 1'b0;
        reqAddr = '0;
        reqIsWrite = 1'b0;
        reqWriteValue = '0;
        framesSeen = 0;
        for (int i = 0; i < ProgramBytes; i++) begin
            progBytes[i] = 8'($urandom());
        end
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        checkResetState();
        loadProgram();
        readBackProgram();
        writeThenRead();
        uartWrites();
        unmappedAccess();
        repeat (2) @(negedge clk);
        if (SocTop_i.socTopChecker_i.failCount == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures in the bound checker",
                SocTop_i.socTopChecker_i.failCount);
            $display("TESTBENCH FAILED");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

// File: all.f
source/SocPkg.sv
source/LineAccessIf.sv
source/BootLoader.sv
source/AccessDecode.sv
source/LineMemory.sv
source/UartTransmitter.sv
source/AccessResult.sv
source/SocTop.sv
sim/SocTop_checker.sv
sim/SocTop_tb.sv
